// File: all.f
fp_slice_pkg.sv
latency_timer.sv
slice_ctrl.sv
lane_noncomp.sv
result_packer.sv
fp_slice_top.sv
tb_fp_slice.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the testbench with Verilator, then judge the log

rm -rf obj_dir build.log sim.log

verilator --binary --timing --assert --top-module tb_fp_slice -f all.f \
  > build.log 2>&1 || { cat build.log; echo "Build failed"; exit 1; }

./obj_dir/Vtb_fp_slice > sim.log 2>&1
cat sim.log

grep -q "Checks failed" sim.log && { echo "Simulation FAILED"; exit 1; }
grep -q "All checks passed" sim.log \
  && { echo "Simulation PASSED"; exit 0; } \
  || { echo "Simulation FAILED"; exit 1; }

// File: tb_fp_slice.sv
`timescale 1ns/100ps
`default_nettype none

module tb_fp_slice;
  import fp_slice_pkg::*;

  localparam int CLK_PERIOD      = 4;
  localparam int RESET_CYCLES    = 10;
  localparam int SEED            = 19;
  localparam int MAX_WAIT        = 20;
  localparam int N_DIRECTED      = 27;
  localparam int N_RAND_FP32     = 40;
  localparam int N_RAND_VEC      = 30;
  localparam int NUM_OPS         = N_DIRECTED + N_RAND_FP32 + N_RAND_VEC;
  localparam int WATCHDOG_CYCLES = NUM_OPS * 20 + RESET_CYCLES;

  logic       clk_i;
  logic       arst_n_i;
  logic       in_valid_i;
  logic       in_ready_o;
  slice_req_t req_i;
  logic       flush_i;
  logic       out_valid_o;
  logic       out_ready_i;
  slice_rsp_t rsp_o;
  logic       busy_o;
  tag_t       next_tag;

  fp_slice_top fp_slice_top_inst (
    .clk_i       (clk_i),
    .arst_n_i    (arst_n_i),
    .in_valid_i  (in_valid_i),
    .in_ready_o  (in_ready_o),
    .req_i       (req_i),
    .flush_i     (flush_i),
    .out_valid_o (out_valid_o),
    .out_ready_i (out_ready_i),
    .rsp_o       (rsp_o),
    .busy_o      (busy_o)
  );

  always #(CLK_PERIOD / 2) clk_i = ~clk_i;

  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    report_failure("Watchdog expired before all tests finished");
  end

  // --------------------
  // Reporting
  // --------------------
  task automatic report_failure(input string msg);
    $display("%s", msg);
    $display("Checks failed");
    $fatal(1);
  endtask

  task automatic check_val(input string name, input logic [63:0] exp, input logic [63:0] act);
    assert (act === exp)
      else report_failure($sformatf("error %s: expected %h, actual %h", name, exp, act));
  endtask

  // --------------------
  // Reference model
  // --------------------
  // Returns {invalid, result}; FP16 values sit in the low half
  function automatic logic [32:0] lane_ref(slice_op_e op, logic wide, data_t a, data_t b);
    logic        sa;
    logic        sb;
    logic        nan_a;
    logic        nan_b;
    logic        snan_a;
    logic        snan_b;
    logic        rs;
    logic [30:0] ma;
    logic [30:0] mb;
    longint      ka;
    longint      kb;
    data_t       res;
    data_t       canon;
    logic        inv;
    if (wide) begin
      sa     = a[31];
      sb     = b[31];
      ma     = a[30:0];
      mb     = b[30:0];
      nan_a  = (a[30:23] == 8'hFF) && (a[22:0] != 23'd0);
      nan_b  = (b[30:23] == 8'hFF) && (b[22:0] != 23'd0);
      snan_a = nan_a && !a[22];
      snan_b = nan_b && !b[22];
      canon  = FP32_CANON_NAN;
    end else begin
      sa     = a[15];
      sb     = b[15];
      ma     = {16'd0, a[14:0]};
      mb     = {16'd0, b[14:0]};
      nan_a  = (a[14:10] == 5'h1F) && (a[9:0] != 10'd0);
      nan_b  = (b[14:10] == 5'h1F) && (b[9:0] != 10'd0);
      snan_a = nan_a && !a[9];
      snan_b = nan_b && !b[9];
      canon  = {16'd0, FP16_CANON_NAN};
    end
    // Total order key, -0 maps just below +0
    ka  = sa ? -(longint'(ma) + 1) : longint'(ma);
    kb  = sb ? -(longint'(mb) + 1) : longint'(mb);
    inv = 1'b0;
    if (op == OP_MIN || op == OP_MAX) begin
      inv = snan_a || snan_b;
      if (nan_a && nan_b) begin
        res = canon;
      end else if (nan_a) begin
        res = b;
      end else if (nan_b) begin
        res = a;
      end else if (op == OP_MIN) begin
        res = (ka <= kb) ? a : b;
      end else begin
        res = (ka >= kb) ? a : b;
      end
    end else begin
      if (op == OP_SGNJ) begin
        rs = sb;
      end else if (op == OP_SGNJN) begin
        rs = !sb;
      end else begin
        rs = sa ^ sb;
      end
      res = wide ? {rs, ma} : {16'd0, rs, ma[14:0]};
    end
    return {inv, res};
  endfunction

  function automatic slice_rsp_t model_rsp(slice_req_t req);
    slice_rsp_t rsp;
    logic [32:0] lo;
    logic [32:0] hi;
    rsp.tag = req.tag;
    if (req.fmt == FMT_FP32) begin
      lo          = lane_ref(req.op, 1'b1, req.operand_a, req.operand_b);
      rsp.result  = lo[31:0];
      rsp.invalid = lo[32];
    end else begin
      lo = lane_ref(req.op, 1'b0, {16'd0, req.operand_a[15:0]}, {16'd0, req.operand_b[15:0]});
      hi = lane_ref(req.op, 1'b0, {16'd0, req.operand_a[31:16]}, {16'd0, req.operand_b[31:16]});
      if (req.vectorial) begin
        rsp.result  = {hi[15:0], lo[15:0]};
        rsp.invalid = lo[32] | hi[32];
      end else begin
        rsp.result  = {16'hFFFF, lo[15:0]};
        rsp.invalid = lo[32];
      end
    end
    return rsp;
  endfunction

  // --------------------
  // Stimulus helpers
  // --------------------
  // Exponent forced to all ones now and then, so NaNs show up
  function automatic data_t rand_fp32();
    data_t val;
    val = $urandom;
    if ($urandom_range(3) == 0) begin
      val[30:23] = 8'hFF;
    end
    return val;
  endfunction

  function automatic lane16_t rand_fp16();
    lane16_t val;
    val = 16'($urandom);
    if ($urandom_range(3) == 0) begin
      val[14:10] = 5'h1F;
    end
    return val;
  endfunction

  function automatic tag_t claim_tag();
    tag_t tag;
    tag      = next_tag;
    next_tag = next_tag + 1'b1;
    return tag;
  endfunction

  function automatic slice_req_t make_req(slice_op_e op, fp_fmt_e fmt, logic vec,
                                          data_t a, data_t b);
    slice_req_t req;
    req.op        = op;
    req.fmt       = fmt;
    req.vectorial = vec;
    req.tag       = claim_tag();
    req.operand_a = a;
    req.operand_b = b;
    return req;
  endfunction

  // Called on a falling edge, returns on the falling edge after accept
  task automatic send_req(input slice_req_t req);
    int waited;
    waited = 0;
    while (!in_ready_o) begin
      @(negedge clk_i);
      waited++;
      assert (waited < MAX_WAIT) else report_failure("The DUT never raised in_ready_o");
    end
    in_valid_i = 1'b1;
    req_i      = req;
    @(posedge clk_i);
    @(negedge clk_i);
    in_valid_i = 1'b0;
  endtask

  task automatic wait_valid(output int cycles);
    cycles = 0;
    while (!out_valid_o) begin
      @(negedge clk_i);
      cycles++;
      assert (cycles < MAX_WAIT) else report_failure("Timed out waiting for out_valid_o");
    end
  endtask

  task automatic run_op(input string name, input slice_op_e op, input fp_fmt_e fmt,
                        input logic vec, input data_t a, input data_t b);
    slice_req_t req;
    int         cycles;
    req = make_req(op, fmt, vec, a, b);
    send_req(req);
    wait_valid(cycles);
    check_val({name, " latency"}, 64'(NUM_PIPE_CYCLES), 64'(cycles));
    check_val(name, 64'(model_rsp(req)), 64'(rsp_o));
    @(posedge clk_i);
    @(negedge clk_i);
    check_val({name, " ready after transfer"}, 64'(1), 64'(in_ready_o));
    check_val({name, " valid after transfer"}, 64'(0), 64'(out_valid_o));
  endtask

  // --------------------
  // Tests
  // --------------------
  task automatic test_first_op();
    check_val("reset in_ready", 64'(1), 64'(in_ready_o));
    check_val("reset out_valid", 64'(0), 64'(out_valid_o));
    check_val("reset busy", 64'(0), 64'(busy_o));
    run_op("first sgnj", OP_SGNJ, FMT_FP32, 1'b0, 32'h3F80_0000, 32'hC000_0000);
  endtask

  task automatic test_fp32();
    int         i;
    logic [2:0] op_bits;
    run_op("fp32 sgnj", OP_SGNJ, FMT_FP32, 1'b0, 32'h3F80_0000, 32'hC000_0000);
    run_op("fp32 sgnjn", OP_SGNJN, FMT_FP32, 1'b0, 32'h3F80_0000, 32'hC000_0000);
    run_op("fp32 sgnjx", OP_SGNJX, FMT_FP32, 1'b0, 32'hBF80_0000, 32'hC000_0000);
    run_op("fp32 min -0 +0", OP_MIN, FMT_FP32, 1'b0, 32'h8000_0000, 32'h0000_0000);
    run_op("fp32 max -0 +0", OP_MAX, FMT_FP32, 1'b0, 32'h8000_0000, 32'h0000_0000);
    run_op("fp32 min +0 -0", OP_MIN, FMT_FP32, 1'b0, 32'h0000_0000, 32'h8000_0000);
    run_op("fp32 min qnan", OP_MIN, FMT_FP32, 1'b0, 32'h7FC0_0001, 32'h4000_0000);
    run_op("fp32 max qnan", OP_MAX, FMT_FP32, 1'b0, 32'h4040_0000, 32'hFFC0_0000);
    run_op("fp32 min two nan", OP_MIN, FMT_FP32, 1'b0, 32'h7FC0_0000, 32'h7FD0_0000);
    run_op("fp32 max snan qnan", OP_MAX, FMT_FP32, 1'b0, 32'h7F80_0001, 32'h7FC0_0000);
    run_op("fp32 min snan", OP_MIN, FMT_FP32, 1'b0, 32'h7F80_0001, 32'h3F80_0000);
    run_op("fp32 sgnj snan", OP_SGNJ, FMT_FP32, 1'b0, 32'h7F80_0001, 32'h3F80_0000);
    for (i = 0; i < N_RAND_FP32; i++) begin
      op_bits = 3'($urandom_range(4));
      run_op($sformatf("fp32 random %0d", i), slice_op_e'(op_bits), FMT_FP32, 1'b0,
             rand_fp32(), rand_fp32());
    end
  endtask

  // Upper halves hold junk and signaling NaNs that must not leak out
  task automatic test_fp16_scalar();
    run_op("fp16 sgnj", OP_SGNJ, FMT_FP16, 1'b0, 32'h1234_3C00, 32'hFFFF_C000);
    run_op("fp16 min -0 +0", OP_MIN, FMT_FP16, 1'b0, 32'h7C01_8000, 32'h7D00_0000);
    run_op("fp16 max qnan", OP_MAX, FMT_FP16, 1'b0, 32'h7C01_7E01, 32'h7C02_4000);
    run_op("fp16 min snan", OP_MIN, FMT_FP16, 1'b0, 32'h0000_7C01, 32'h5555_3C00);
    run_op("fp16 sgnjx", OP_SGNJX, FMT_FP16, 1'b0, 32'hA5A5_BC00, 32'h7C01_C000);
  endtask

  task automatic test_fp16_vector();
    int         i;
    logic [2:0] op_bits;
    run_op("vec min upper snan", OP_MIN, FMT_FP16, 1'b1, 32'h7C01_3C00, 32'h4000_3800);
    run_op("vec max lower snan", OP_MAX, FMT_FP16, 1'b1, 32'h3C00_7C01, 32'hBC00_4000);
    run_op("vec sgnjx", OP_SGNJX, FMT_FP16, 1'b1, 32'hBC00_3C00, 32'hC000_C000);
    run_op("vec min zeros nan", OP_MIN, FMT_FP16, 1'b1, 32'h8000_7E00, 32'h0000_7E00);
    for (i = 0; i < N_RAND_VEC; i++) begin
      op_bits = 3'($urandom_range(4));
      run_op($sformatf("vec random %0d", i), slice_op_e'(op_bits), FMT_FP16, 1'b1,
             {rand_fp16(), rand_fp16()}, {rand_fp16(), rand_fp16()});
    end
  endtask

  task automatic test_backpressure();
    slice_req_t req;
    slice_rsp_t held;
    int         cycles;
    int         i;
    req         = make_req(OP_MAX, FMT_FP16, 1'b1, 32'h4000_BC00, 32'h3C00_C000);
    out_ready_i = 1'b0;
    send_req(req);
    wait_valid(cycles);
    check_val("backpressure latency", 64'(NUM_PIPE_CYCLES), 64'(cycles));
    held = rsp_o;
    check_val("backpressure result", 64'(model_rsp(req)), 64'(held));
    for (i = 0; i < 8; i++) begin
      @(negedge clk_i);
      check_val("backpressure valid", 64'(1), 64'(out_valid_o));
      check_val("backpressure rsp", 64'(held), 64'(rsp_o));
      check_val("backpressure ready", 64'(0), 64'(in_ready_o));
    end
    out_ready_i = 1'b1;
    @(posedge clk_i);
    @(negedge clk_i);
    check_val("backpressure ready after transfer", 64'(1), 64'(in_ready_o));
    check_val("backpressure valid after transfer", 64'(0), 64'(out_valid_o));
  endtask

  task automatic expect_quiet(input string name);
    int i;
    check_val({name, " busy"}, 64'(0), 64'(busy_o));
    check_val({name, " ready"}, 64'(1), 64'(in_ready_o));
    for (i = 0; i < 6; i++) begin
      check_val({name, " valid"}, 64'(0), 64'(out_valid_o));
      @(negedge clk_i);
    end
  endtask

  task automatic test_flush();
    int cycles;
    // Drop the operation while the timer is still running
    send_req(make_req(OP_MAX, FMT_FP32, 1'b0, 32'h4000_0000, 32'h3F80_0000));
    check_val("flush wait busy", 64'(1), 64'(busy_o));
    flush_i = 1'b1;
    @(posedge clk_i);
    @(negedge clk_i);
    flush_i = 1'b0;
    expect_quiet("flush in wait");
    run_op("after wait flush", OP_MIN, FMT_FP32, 1'b0, 32'hC040_0000, 32'h3F80_0000);
    // Drop it again while the result is held
    out_ready_i = 1'b0;
    send_req(make_req(OP_SGNJN, FMT_FP16, 1'b1, 32'h3C00_3C00, 32'h8000_0000));
    wait_valid(cycles);
    check_val("flush hold latency", 64'(NUM_PIPE_CYCLES), 64'(cycles));
    flush_i = 1'b1;
    @(posedge clk_i);
    @(negedge clk_i);
    flush_i     = 1'b0;
    out_ready_i = 1'b1;
    expect_quiet("flush in hold");
    run_op("after hold flush", OP_SGNJX, FMT_FP16, 1'b1, 32'hBC00_4000, 32'h8000_C000);
  endtask

  // --------------------
  // Main sequence
  // --------------------
  initial begin
    void'($urandom(SEED));
    clk_i       = 1'b0;
    arst_n_i    = 1'b0;
    in_valid_i  = 1'b0;
    req_i       = '0;
    flush_i     = 1'b0;
    out_ready_i = 1'b1;
    next_tag    = '0;
    repeat (RESET_CYCLES) @(posedge clk_i);
    @(negedge clk_i);
    arst_n_i = 1'b1;
    @(negedge clk_i);
    test_first_op();
    test_fp32();
    test_fp16_scalar();
    test_fp16_vector();
    test_backpressure();
    test_flush();
    $display("All checks passed");
    $finish;
  end

endmodule

`default_nettype wire

// File: fp_slice_top.sv
`timescale 1ns/100ps
`default_nettype none

module fp_slice_top (
  input  logic                     clk_i,
  input  logic                     arst_n_i,
  input  logic                     in_valid_i,
  output logic                     in_ready_o,
  input  fp_slice_pkg::slice_req_t req_i,
  input  logic                     flush_i,
  output logic                     out_valid_o,
  input  logic                     out_ready_i,
  output fp_slice_pkg::slice_rsp_t rsp_o,
  output logic                     busy_o
);
  import fp_slice_pkg::*;

  logic       load;
  logic       timer_start;
  logic       timer_clear;
  logic       timer_done;
  data_t      lane0_result;
  data_t      lane1_result;
  logic [1:0] lane_invalid;

  // --------------------
  // Control
  // --------------------
  slice_ctrl slice_ctrl_inst (
    .clk_i         (clk_i),
    .arst_n_i      (arst_n_i),
    .in_valid_i    (in_valid_i),
    .flush_i       (flush_i),
    .out_ready_i   (out_ready_i),
    .timer_done_i  (timer_done),
    .in_ready_o    (in_ready_o),
    .load_o        (load),
    .timer_start_o (timer_start),
    .timer_clear_o (timer_clear),
    .out_valid_o   (out_valid_o),
    .busy_o        (busy_o)
  );

  latency_timer latency_timer_inst (
    .clk_i    (clk_i),
    .arst_n_i (arst_n_i),
    .start_i  (timer_start),
    .clear_i  (timer_clear),
    .done_o   (timer_done)
  );

  // --------------------
  // Datapath
  // --------------------
  lane_noncomp #(
    .LANE_IDX (0)
  ) lane0_inst (
    .clk_i         (clk_i),
    .arst_n_i      (arst_n_i),
    .load_i        (load),
    .req_i         (req_i),
    .lane_result_o (lane0_result),
    .invalid_o     (lane_invalid[0])
  );

  lane_noncomp #(
    .LANE_IDX (1)
  ) lane1_inst (
    .clk_i         (clk_i),
    .arst_n_i      (arst_n_i),
    .load_i        (load),
    .req_i         (req_i),
    .lane_result_o (lane1_result),
    .invalid_o     (lane_invalid[1])
  );

  result_packer result_packer_inst (
    .clk_i          (clk_i),
    .arst_n_i       (arst_n_i),
    .load_i         (load),
    .req_i          (req_i),
    .lane0_result_i (lane0_result),
    .lane1_result_i (lane1_result),
    .lane_invalid_i (lane_invalid),
    .rsp_o          (rsp_o)
  );

endmodule

`default_nettype wire

// File: result_packer.sv
`timescale 1ns/100ps
`default_nettype none

module result_packer (
  input  logic                     clk_i,
  input  logic                     arst_n_i,
  input  logic                     load_i,
  input  fp_slice_pkg::slice_req_t req_i,
  input  fp_slice_pkg::data_t      lane0_result_i,
  input  fp_slice_pkg::data_t      lane1_result_i,
  input  logic [1:0]               lane_invalid_i,
  output fp_slice_pkg::slice_rsp_t rsp_o
);
  import fp_slice_pkg::*;

  fp_fmt_e fmt_q;
  logic    vec_q;
  tag_t    tag_q;
  logic    vec_fp16;

  // Metadata travels alongside the lanes
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      fmt_q <= FMT_FP32;
      vec_q <= 1'b0;
      tag_q <= '0;
    end else if (load_i) begin
      fmt_q <= req_i.fmt;
      vec_q <= req_i.vectorial;
      tag_q <= req_i.tag;
    end
  end

  // Upper lane is live only for packed FP16
  assign vec_fp16 = (fmt_q == FMT_FP16) & vec_q;

  // --------------------
  // Result assembly
  // --------------------
  always_comb begin
    rsp_o.tag     = tag_q;
    rsp_o.invalid = lane_invalid_i[0] | (vec_fp16 & lane_invalid_i[1]);
    if (fmt_q == FMT_FP32) begin
      rsp_o.result = lane0_result_i;
    end else if (vec_fp16) begin
      rsp_o.result = {lane1_result_i[FP16_W-1:0], lane0_result_i[FP16_W-1:0]};
    end else begin
      // NaN-box the scalar half
      rsp_o.result = {{FP16_W{1'b1}}, lane0_result_i[FP16_W-1:0]};
    end
  end

endmodule

`default_nettype wire

// File: lane_noncomp.sv
`timescale 1ns/100ps
`default_nettype none

module lane_noncomp #(
  parameter int unsigned LANE_IDX = 0
) (
  input  logic                     clk_i,
  input  logic                     arst_n_i,
  input  logic                     load_i,
  input  fp_slice_pkg::slice_req_t req_i,
  output fp_slice_pkg::data_t      lane_result_o,
  output logic                     invalid_o
);
  import fp_slice_pkg::*;

  // Sign, magnitude and NaN class of one operand
  typedef struct packed {
    logic                sign;
    logic [DATA_W-2:0]   mag;
    logic                nan;
    logic                snan;
  } fp_class_t;

  function automatic fp_class_t classify(data_t val, fp_fmt_e fmt);
    fp_class_t cls;
    if (fmt == FMT_FP32) begin
      cls.sign = val[31];
      cls.mag  = val[30:0];
      cls.nan  = (&val[30:23]) & (|val[22:0]);
      cls.snan = cls.nan & ~val[22];
    end else begin
      cls.sign = val[15];
      cls.mag  = {{FP16_W{1'b0}}, val[14:0]};
      cls.nan  = (&val[14:10]) & (|val[9:0]);
      cls.snan = cls.nan & ~val[9];
    end
    return cls;
  endfunction

  slice_op_e op_q;
  fp_fmt_e   fmt_q;
  fp_fmt_e   fmt_d;
  data_t     opa_q;
  data_t     opb_q;
  data_t     opa_d;
  data_t     opb_d;
  fp_class_t cls_a;
  fp_class_t cls_b;
  logic      inj_sign;
  logic      a_lt_b;
  logic      is_minmax;
  data_t     inject_res;
  data_t     minmax_res;
  data_t     canon_nan;

  // --------------------
  // Operand slice
  // --------------------
  always_comb begin
    if (LANE_IDX == 0) begin
      fmt_d = req_i.fmt;
      if (req_i.fmt == FMT_FP32) begin
        opa_d = req_i.operand_a;
        opb_d = req_i.operand_b;
      end else begin
        opa_d = {{FP16_W{1'b0}}, req_i.operand_a[FP16_W-1:0]};
        opb_d = {{FP16_W{1'b0}}, req_i.operand_b[FP16_W-1:0]};
      end
    end else begin
      // Upper lane only ever sees FP16 halves
      fmt_d = FMT_FP16;
      opa_d = {{FP16_W{1'b0}}, req_i.operand_a[DATA_W-1:FP16_W]};
      opb_d = {{FP16_W{1'b0}}, req_i.operand_b[DATA_W-1:FP16_W]};
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      op_q  <= OP_SGNJ;
      fmt_q <= FMT_FP32;
    end else if (load_i) begin
      op_q  <= req_i.op;
      fmt_q <= fmt_d;
    end
  end

  always_ff @(posedge clk_i) begin
    if (load_i) begin
      opa_q <= opa_d;
      opb_q <= opb_d;
    end
  end

  assign cls_a = classify(opa_q, fmt_q);
  assign cls_b = classify(opb_q, fmt_q);

  // --------------------
  // Sign injection
  // --------------------
  always_comb begin
    case (op_q)
      OP_SGNJN: inj_sign = ~cls_b.sign;
      OP_SGNJX: inj_sign = cls_a.sign ^ cls_b.sign;
      default:  inj_sign = cls_b.sign;
    endcase
    if (fmt_q == FMT_FP32) begin
      inject_res = {inj_sign, opa_q[30:0]};
    end else begin
      inject_res = {{FP16_W{1'b0}}, inj_sign, opa_q[14:0]};
    end
  end

  // --------------------
  // Min / max
  // --------------------
  assign canon_nan = (fmt_q == FMT_FP32) ? FP32_CANON_NAN
                                         : {{FP16_W{1'b0}}, FP16_CANON_NAN};

  always_comb begin
    // Differing signs order -0 below +0 as well
    if (cls_a.sign != cls_b.sign) begin
      a_lt_b = cls_a.sign;
    end else if (cls_a.sign) begin
      a_lt_b = cls_a.mag > cls_b.mag;
    end else begin
      a_lt_b = cls_a.mag < cls_b.mag;
    end

    if (cls_a.nan && cls_b.nan) begin
      minmax_res = canon_nan;
    end else if (cls_a.nan) begin
      minmax_res = opb_q;
    end else if (cls_b.nan) begin
      minmax_res = opa_q;
    end else if (op_q == OP_MIN) begin
      minmax_res = a_lt_b ? opa_q : opb_q;
    end else begin
      minmax_res = a_lt_b ? opb_q : opa_q;
    end
  end

  assign is_minmax     = (op_q == OP_MIN) || (op_q == OP_MAX);
  assign lane_result_o = is_minmax ? minmax_res : inject_res;
  assign invalid_o     = is_minmax & (cls_a.snan | cls_b.snan);

endmodule

`default_nettype wire

// File: slice_ctrl.sv
`timescale 1ns/100ps
`default_nettype none

module slice_ctrl (
  input  logic clk_i,
  input  logic arst_n_i,
  input  logic in_valid_i,
  input  logic flush_i,
  input  logic out_ready_i,
  input  logic timer_done_i,
  output logic in_ready_o,
  output logic load_o,
  output logic timer_start_o,
  output logic timer_clear_o,
  output logic out_valid_o,
  output logic busy_o
);
  import fp_slice_pkg::*;

  ctrl_state_e state_q;
  ctrl_state_e state_d;
  logic        accept;

  // --------------------
  // Handshake decode
  // --------------------
  assign in_ready_o    = (state_q == IDLE);
  assign out_valid_o   = (state_q == HOLD);
  assign busy_o        = (state_q != IDLE);
  assign accept        = in_valid_i & in_ready_o;
  assign load_o        = accept;
  assign timer_start_o = accept;
  // Abort a pending count when the operation is dropped
  assign timer_clear_o = flush_i & busy_o;

  // --------------------
  // State machine
  // --------------------
  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE: begin
        if (accept) begin
          state_d = WAIT;
        end
      end
      WAIT: begin
        if (flush_i) begin
          state_d = IDLE;
        end else if (timer_done_i) begin
          state_d = HOLD;
        end
      end
      HOLD: begin
        // Flush wins over a pending transfer
        if (flush_i || out_ready_i) begin
          state_d = IDLE;
        end
      end
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q <= IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  a_valid_held: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    out_valid_o && !out_ready_i && !flush_i |=> out_valid_o)
    else $error("out_valid_o dropped without transfer, now in %s", state_q.name());

endmodule

`default_nettype wire

// File: latency_timer.sv
`timescale 1ns/100ps
`default_nettype none

module latency_timer (
  input  logic clk_i,
  input  logic arst_n_i,
  input  logic start_i,
  input  logic clear_i,
  output logic done_o
);
  import fp_slice_pkg::*;

  logic [TIMER_W-1:0] count_q;
  logic               running_q;

  // Down-counter, done on the last count of a running sequence
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      count_q   <= '0;
      running_q <= 1'b0;
    end else if (clear_i) begin
      count_q   <= '0;
      running_q <= 1'b0;
    end else if (start_i) begin
      count_q   <= TIMER_W'(NUM_PIPE_CYCLES - 1);
      running_q <= 1'b1;
    end else if (running_q) begin
      if (count_q == '0) begin
        running_q <= 1'b0;
      end else begin
        count_q <= count_q - 1'b1;
      end
    end
  end

  assign done_o = running_q & (count_q == '0);

  // Only one operation may be in flight
  a_no_restart: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    start_i |-> !running_q)
    else $error("Timer restarted while counting, count %0d", count_q);

endmodule

`default_nettype wire

// File: fp_slice_pkg.sv
`default_nettype none

package fp_slice_pkg;

  // --------------------
  // Widths and timing
  // --------------------
  localparam int unsigned DATA_W          = 32;
  localparam int unsigned FP16_W          = 16;
  localparam int unsigned NUM_LANES       = 2;
  localparam int unsigned NUM_PIPE_CYCLES = 3;
  localparam int unsigned TIMER_W         = 2;
  localparam int unsigned TAG_W           = 4;

  // Canonical quiet NaNs
  localparam logic [DATA_W-1:0] FP32_CANON_NAN = 32'h7FC0_0000;
  localparam logic [FP16_W-1:0] FP16_CANON_NAN = 16'h7E00;

  typedef logic [DATA_W-1:0] data_t;
  typedef logic [FP16_W-1:0] lane16_t;
  typedef logic [TAG_W-1:0]  tag_t;

  // --------------------
  // Encodings
  // --------------------
  typedef enum logic {
    FMT_FP32 = 1'b0,
    FMT_FP16 = 1'b1
  } fp_fmt_e;

  typedef enum logic [2:0] {
    OP_SGNJ  = 3'd0,
    OP_SGNJN = 3'd1,
    OP_SGNJX = 3'd2,
    OP_MIN   = 3'd3,
    OP_MAX   = 3'd4
  } slice_op_e;

  // Controller states
  typedef enum logic [1:0] {
    IDLE = 2'd0,
    WAIT = 2'd1,
    HOLD = 2'd2
  } ctrl_state_e;

  // --------------------
  // Request and response
  // --------------------
  typedef struct packed {
    slice_op_e op;
    fp_fmt_e   fmt;
    logic      vectorial;
    tag_t      tag;
    data_t     operand_a;
    data_t     operand_b;
  } slice_req_t;

  typedef struct packed {
    data_t result;
    logic  invalid;
    tag_t  tag;
  } slice_rsp_t;

endpackage

`default_nettype wire
